// ==== pingpong_pkg.sv ====
package pingpong_pkg;

    localparam int COUNT_W      = 4;
    localparam int STEP_DIV     = 16;              // clk cycles per step
    localparam int SCAN_DIV     = 4;               // clk cycles per digit
    localparam int STEP_CNT_W   = $clog2(STEP_DIV);
    localparam int SCAN_CNT_W   = $clog2(SCAN_DIV);
    localparam int DEBOUNCE_LEN = 4;               // Stable samples for a press

    localparam logic [3:0] ADDR_CTRL   = 4'h0;
    localparam logic [3:0] ADDR_LIMITS = 4'h4;
    localparam logic [3:0] ADDR_STATUS = 4'h8;

    typedef enum logic {
        DIR_DOWN = 1'b0,
        DIR_UP   = 1'b1
    } dir_e;

    typedef enum logic [3:0] {
        GLYPH_0, GLYPH_1, GLYPH_2, GLYPH_3, GLYPH_4,
        GLYPH_5, GLYPH_6, GLYPH_7, GLYPH_8, GLYPH_9,
        GLYPH_UP   = 4'd14,
        GLYPH_DOWN = 4'd15
    } glyph_e;

    // Active low, bit 6 is segment a
    localparam logic [6:0] SEG_CODE [0:15] = '{
        7'b0000001,     // 0
        7'b1001111,     // 1
        7'b0010010,
        7'b0000110,
        7'b1001100,
        7'b0100100,     // 5
        7'b0100000,
        7'b0001111,
        7'b0000000,
        7'b0000100,     // 9
        7'b0000001,     // Codes 10 to 13 unused
        7'b0000001,
        7'b0000001,
        7'b0000001,
        7'b0011101,     // Up arrow
        7'b1100011      // Down arrow
    };

endpackage

// ==== pingpong_regs.sv ====
module pingpong_regs (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 psel,
    input  logic                                 penable,
    input  logic                                 pwrite,
    input  logic [3:0]                           paddr,
    input  logic [31:0]                          pwdata,
    output logic [31:0]                          prdata,
    output logic                                 pready,
    output logic                                 pslverr,
    input  logic [pingpong_pkg::COUNT_W-1:0]     count,
    input  pingpong_pkg::dir_e                   direction,
    output logic                                 enable,
    output logic [pingpong_pkg::COUNT_W-1:0]     max,
    output logic [pingpong_pkg::COUNT_W-1:0]     min
);

    logic sel_ctrl;
    logic sel_limits;
    logic sel_status;
    logic addr_ok;
    logic access;
    logic wr_access;
    logic rd_access;

    assign sel_ctrl   = (paddr == pingpong_pkg::ADDR_CTRL);
    assign sel_limits = (paddr == pingpong_pkg::ADDR_LIMITS);
    assign sel_status = (paddr == pingpong_pkg::ADDR_STATUS);
    assign addr_ok    = sel_ctrl | sel_limits | sel_status;

    assign access    = psel & penable;              // Zero wait, one access cycle
    assign wr_access = access & pwrite;
    assign rd_access = access & ~pwrite;

    assign pready  = 1'b1;
    assign pslverr = access & (~addr_ok | (pwrite & sel_status));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            enable <= 1'b0;
            min    <= '0;
            max    <= pingpong_pkg::COUNT_W'(9);
        end else if (wr_access) begin
            if (sel_ctrl) begin
                enable <= pwdata[0];
            end
            if (sel_limits) begin
                min <= pwdata[3:0];
                max <= pwdata[7:4];
            end
        end
    end

    // Read mux, STATUS is sampled live from the counter
    always_comb begin
        prdata = '0;
        if (rd_access) begin
            if (sel_ctrl) begin
                prdata[0] = enable;
            end else if (sel_limits) begin
                prdata[3:0] = min;
                prdata[7:4] = max;
            end else if (sel_status) begin
                prdata[3:0] = count;
                prdata[4]   = direction;
            end
        end
    end

endmodule

// ==== button_conditioner.sv ====
module button_conditioner (
    input  logic clk,
    input  logic reset,
    input  logic button,
    input  logic step_tick,
    output logic request
);

    logic [pingpong_pkg::DEBOUNCE_LEN-1:0] samples;
    logic                                  accepted;
    logic                                  accepted_d;
    logic                                  press;

    // Button is accepted once every stage has seen it high
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            samples <= '0;
        end else begin
            samples <= {samples[pingpong_pkg::DEBOUNCE_LEN-2:0], button};
        end
    end

    assign accepted = &samples;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            accepted_d <= 1'b0;
        end else begin
            accepted_d <= accepted;
        end
    end

    assign press = accepted & ~accepted_d;      // One cycle per press

    // Held until the step tick picks it up; a fresh press wins over the clear
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            request <= 1'b0;
        end else if (press) begin
            request <= 1'b1;
        end else if (step_tick) begin
            request <= 1'b0;
        end
    end

endmodule

// ==== tick_gen.sv ====
module tick_gen (
    input  logic clk,
    input  logic reset,
    output logic step_tick,
    output logic scan_tick
);

    logic [pingpong_pkg::STEP_CNT_W-1:0] step_cnt;
    logic [pingpong_pkg::SCAN_CNT_W-1:0] scan_cnt;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            step_cnt  <= '0;
            step_tick <= 1'b0;
        end else if (step_cnt == pingpong_pkg::STEP_CNT_W'(pingpong_pkg::STEP_DIV - 1)) begin
            step_cnt  <= '0;
            step_tick <= 1'b1;                  // Pulse on wrap
        end else begin
            step_cnt  <= step_cnt + 1'b1;
            step_tick <= 1'b0;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            scan_cnt  <= '0;
            scan_tick <= 1'b0;
        end else if (scan_cnt == pingpong_pkg::SCAN_CNT_W'(pingpong_pkg::SCAN_DIV - 1)) begin
            scan_cnt  <= '0;
            scan_tick <= 1'b1;
        end else begin
            scan_cnt  <= scan_cnt + 1'b1;
            scan_tick <= 1'b0;
        end
    end

endmodule

// ==== pingpong_counter.sv ====
module pingpong_counter (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 step_tick,
    input  logic                                 enable,
    input  logic                                 flip_req,
    input  logic                                 restart_req,
    input  logic [pingpong_pkg::COUNT_W-1:0]     max,
    input  logic [pingpong_pkg::COUNT_W-1:0]     min,
    output logic [pingpong_pkg::COUNT_W-1:0]     count,
    output pingpong_pkg::dir_e                   direction
);

    pingpong_pkg::dir_e next_dir;
    logic               limits_ok;
    logic               in_range;
    logic               can_step;

    // Limits force the turnaround, flip only matters in between
    always_comb begin
        if (count == min) begin
            next_dir = pingpong_pkg::DIR_UP;
        end else if (count == max) begin
            next_dir = pingpong_pkg::DIR_DOWN;
        end else if (flip_req) begin
            next_dir = (direction == pingpong_pkg::DIR_UP) ? pingpong_pkg::DIR_DOWN
                                                           : pingpong_pkg::DIR_UP;
        end else begin
            next_dir = direction;
        end
    end

    assign limits_ok = (min < max);
    assign in_range  = (count >= min) && (count <= max);
    assign can_step  = enable && limits_ok && in_range;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count     <= '0;
            direction <= pingpong_pkg::DIR_UP;
        end else if (step_tick) begin
            if (restart_req) begin
                count     <= min;               // Restart ignores enable
                direction <= pingpong_pkg::DIR_UP;
            end else if (can_step) begin
                direction <= next_dir;
                if (next_dir == pingpong_pkg::DIR_UP) begin
                    count <= count + 1'b1;
                end else begin
                    count <= count - 1'b1;
                end
            end
        end
    end

endmodule

// ==== display_driver.sv ====
module display_driver (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 scan_tick,
    input  logic [pingpong_pkg::COUNT_W-1:0]     count,
    input  pingpong_pkg::dir_e                   direction,
    output logic [3:0]                           an,
    output logic [6:0]                           seg
);

    pingpong_pkg::glyph_e dir_glyph;
    pingpong_pkg::glyph_e ones_glyph;
    pingpong_pkg::glyph_e tens_glyph;
    pingpong_pkg::glyph_e glyph;

    // One low anode, rotates left each scan tick
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            an <= 4'b1110;
        end else if (scan_tick) begin
            an <= {an[2:0], an[3]};
        end
    end

    assign dir_glyph  = (direction == pingpong_pkg::DIR_UP) ? pingpong_pkg::GLYPH_UP
                                                            : pingpong_pkg::GLYPH_DOWN;
    assign ones_glyph = pingpong_pkg::glyph_e'(count % 4'd10);
    assign tens_glyph = pingpong_pkg::glyph_e'(count / 4'd10);

    always_comb begin
        case (an)
            4'b1110,
            4'b1101: glyph = dir_glyph;         // Two direction digits
            4'b1011: glyph = ones_glyph;
            4'b0111: glyph = tens_glyph;
            default: glyph = pingpong_pkg::GLYPH_0;
        endcase
    end

    assign seg = pingpong_pkg::SEG_CODE[glyph];

endmodule

// ==== pingpong_top.sv ====
module pingpong_top (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 psel,
    input  logic                                 penable,
    input  logic                                 pwrite,
    input  logic [3:0]                           paddr,
    input  logic [31:0]                          pwdata,
    output logic [31:0]                          prdata,
    output logic                                 pready,
    output logic                                 pslverr,
    input  logic                                 flip_button,
    input  logic                                 restart_button,
    output logic [pingpong_pkg::COUNT_W-1:0]     led_count,
    output logic                                 led_up,
    output logic [3:0]                           an,
    output logic [6:0]                           seg
);

    logic                                enable;
    logic [pingpong_pkg::COUNT_W-1:0]    max;
    logic [pingpong_pkg::COUNT_W-1:0]    min;
    logic                                step_tick;
    logic                                scan_tick;
    logic                                flip_req;
    logic                                restart_req;
    pingpong_pkg::dir_e                  direction;

    assign led_up = (direction == pingpong_pkg::DIR_UP);

    pingpong_regs i_regs (
        .clk(clk), .reset(reset),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
        .pready(pready), .pslverr(pslverr),
        .count(led_count), .direction(direction),
        .enable(enable), .max(max), .min(min)
    );

    tick_gen i_tick_gen (
        .clk(clk), .reset(reset),
        .step_tick(step_tick), .scan_tick(scan_tick)
    );

    button_conditioner i_flip_btn (
        .clk(clk), .reset(reset), .button(flip_button),
        .step_tick(step_tick), .request(flip_req)
    );

    button_conditioner i_restart_btn (
        .clk(clk), .reset(reset), .button(restart_button),
        .step_tick(step_tick), .request(restart_req)
    );

    pingpong_counter i_counter (
        .clk(clk), .reset(reset), .step_tick(step_tick), .enable(enable),
        .flip_req(flip_req), .restart_req(restart_req),
        .max(max), .min(min), .count(led_count), .direction(direction)
    );

    display_driver i_display (
        .clk(clk), .reset(reset), .scan_tick(scan_tick),
        .count(led_count), .direction(direction), .an(an), .seg(seg)
    );

endmodule

// ==== pingpong_assertions.sv ====
module pingpong_checker (
    input logic        clk,
    input logic        reset,
    input logic        psel,
    input logic        penable,
    input logic        pwrite,
    input logic [3:0]  paddr,
    input logic [31:0] pwdata,
    input logic        pslverr,
    input logic [3:0]  led_count,
    input logic        led_up,
    input logic [3:0]  an,
    input logic [6:0]  seg
);

    logic       enable_q;
    logic [3:0] min_q;
    logic [3:0] max_q;
    logic       bad_addr;
    logic       restarted;
    int         fail_count;

    // Shadow of the last written CTRL and LIMITS
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            enable_q <= 1'b0;
            min_q    <= 4'd0;
            max_q    <= 4'd9;
        end else if (psel && penable && pwrite) begin
            if (paddr == pingpong_pkg::ADDR_CTRL) begin
                enable_q <= pwdata[0];
            end
            if (paddr == pingpong_pkg::ADDR_LIMITS) begin
                min_q <= pwdata[3:0];
                max_q <= pwdata[7:4];
            end
        end
    end

    assign bad_addr = (paddr != pingpong_pkg::ADDR_CTRL) && (paddr != pingpong_pkg::ADDR_LIMITS)
                      && (paddr != pingpong_pkg::ADDR_STATUS);
    assign restarted = (led_count == min_q) && led_up;   // What a restart leaves behind

    function automatic logic [6:0] expected_seg(logic [3:0] anodes, logic [3:0] cnt, logic up);
        logic [3:0] glyph;
        case (anodes)
            4'b1110, 4'b1101: glyph = up ? pingpong_pkg::GLYPH_UP : pingpong_pkg::GLYPH_DOWN;
            4'b1011: glyph = cnt % 4'd10;
            4'b0111: glyph = cnt / 4'd10;
            default: glyph = 4'd0;
        endcase
        return pingpong_pkg::SEG_CODE[glyph];
    endfunction

    initial fail_count = 0;

    a_pslverr: assert property (@(posedge clk) disable iff (reset)
        pslverr == (psel && penable && (bad_addr
                    || (pwrite && paddr == pingpong_pkg::ADDR_STATUS))))
        else begin
            fail_count++;
            $error("pslverr does not match decoded address");
        end

    a_step: assert property (@(posedge clk) disable iff (reset)
        $changed(led_count) |-> (led_up && led_count == $past(led_count) + 4'd1)
                             || (!led_up && led_count == $past(led_count) - 4'd1)
                             || restarted)
        else begin
            fail_count++;
            $error("count moved by more than one step");
        end

    a_range: assert property (@(posedge clk) disable iff (reset)
        $changed(led_count) |-> led_count >= min_q && led_count <= max_q)
        else begin
            fail_count++;
            $error("count left the limits");
        end

    a_hold: assert property (@(posedge clk) disable iff (reset)
        $changed(led_count) && !restarted |-> $past(enable_q) && $past(min_q < max_q))
        else begin
            fail_count++;
            $error("count changed while it should hold");
        end

    a_turn_max: assert property (@(posedge clk) disable iff (reset)
        $changed(led_count) && $past(led_count) == $past(max_q) |-> led_count < $past(led_count))
        else begin
            fail_count++;
            $error("no turnaround at max");
        end

    a_turn_min: assert property (@(posedge clk) disable iff (reset)
        $changed(led_count) && $past(led_count) == $past(min_q) |-> led_count > $past(led_count))
        else begin
            fail_count++;
            $error("no turnaround at min");
        end

    a_anode_onehot: assert property (@(posedge clk) disable iff (reset) $onehot(~an))
        else begin
            fail_count++;
            $error("anode is not one-low");
        end

    a_anode_rotate: assert property (@(posedge clk) disable iff (reset)
        $changed(an) |-> an == {$past(an[2:0]), $past(an[3])})
        else begin
            fail_count++;
            $error("anode did not rotate left");
        end

    a_segments: assert property (@(posedge clk) disable iff (reset)
        seg == expected_seg(an, led_count, led_up))
        else begin
            fail_count++;
            $error("segment pattern wrong for active digit");
        end

endmodule

bind pingpong_top pingpong_checker i_checker (.*);

// ==== tb_pingpong.sv ====
module tb_pingpong;

    logic        clk;
    logic        reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        flip_button;
    logic        restart_button;
    logic [3:0]  led_count;
    logic        led_up;
    logic [3:0]  an;
    logic [6:0]  seg;

    int          seed;
    int          errors;
    int          tests;
    int          failed;
    int          err_mark;
    logic [31:0] rd;
    logic        err;
    logic [3:0]  lo;
    logic [3:0]  hi;
    logic [3:0]  held;

    pingpong_top i_pingpong_top (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        errors++;
    endtask

    task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] data,
                              output logic [31:0] rdata, output logic slverr);
        int t;
        @(posedge clk);
        #2;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #2;
        penable = 1'b1;
        for (t = 0; t < 20; t++) begin
            @(negedge clk);
            if (pready) break;
        end
        if (t == 20) report_timeout("pready");
        rdata  = prdata;
        slverr = pslverr;
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, output logic slverr);
        logic [31:0] unused;
        apb_access(1'b1, addr, data, unused, slverr);
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data,
                            output logic slverr);
        apb_access(1'b0, addr, 32'h0, data, slverr);
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic press_button(input logic restart);
        @(posedge clk);
        #2;
        if (restart) restart_button = 1'b1;
        else flip_button = 1'b1;
        repeat (pingpong_pkg::DEBOUNCE_LEN + 3) @(posedge clk);
        #2;
        restart_button = 1'b0;
        flip_button    = 1'b0;
    endtask

    // Next change of the count
    task automatic wait_step();
        logic [3:0] old;
        int         t;
        @(negedge clk);
        old = led_count;
        for (t = 0; t < 4 * pingpong_pkg::STEP_DIV; t++) begin
            @(negedge clk);
            if (led_count != old) break;
        end
        if (t == 4 * pingpong_pkg::STEP_DIV) report_timeout("a count step");
    endtask

    task automatic wait_count(input logic [3:0] value, input logic up);
        int t;
        for (t = 0; t < 40 * pingpong_pkg::STEP_DIV; t++) begin
            @(negedge clk);
            if (led_count == value && led_up == up) break;
        end
        if (t == 40 * pingpong_pkg::STEP_DIV) report_timeout("a count value");
    endtask

    // Disabled, new limits, restart, then enabled again
    task automatic setup_run(input logic [3:0] min_v, input logic [3:0] max_v);
        apb_write(pingpong_pkg::ADDR_CTRL, 32'h0, err);
        apb_write(pingpong_pkg::ADDR_LIMITS, {24'h0, max_v, min_v}, err);
        press_button(1'b1);
        wait_count(min_v, 1'b1);
        apb_write(pingpong_pkg::ADDR_CTRL, 32'h1, err);
    endtask

    task automatic start_test();
        err_mark = errors + i_pingpong_top.i_checker.fail_count;
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors + i_pingpong_top.i_checker.fail_count != err_mark) begin
            failed++;
            $display("test %s: FAILED", name);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    initial begin
        seed = 32'h6064dce2;
        errors = 0;
        tests = 0;
        failed = 0;
        reset = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = 4'h0;
        pwdata = 32'h0;
        flip_button = 1'b0;
        restart_button = 1'b0;
        repeat (10) @(posedge clk);
        #2 reset = 1'b0;

        start_test();
        apb_read(pingpong_pkg::ADDR_STATUS, rd, err);
        compare("status", rd, 32'h10);              // Count 0, direction up
        apb_write(pingpong_pkg::ADDR_CTRL, 32'h1, err);
        apb_read(pingpong_pkg::ADDR_CTRL, rd, err);
        compare("ctrl", rd, 32'h1);
        apb_write(pingpong_pkg::ADDR_LIMITS, 32'h92, err);
        apb_read(pingpong_pkg::ADDR_LIMITS, rd, err);
        compare("limits", rd, 32'h92);
        apb_read(4'hc, rd, err);
        compare("pslverr", 32'(err), 32'h1);
        apb_write(pingpong_pkg::ADDR_STATUS, 32'h5, err);
        compare("pslverr", 32'(err), 32'h1);
        end_test("registers");

        start_test();
        repeat (4) begin
            rd = $random(seed);
            lo = {1'b0, rd[2:0]};
            hi = lo + 4'd2 + {2'b0, rd[5:4]};
            setup_run(lo, hi);
            repeat (2 * int'(hi - lo) + 1) wait_step();
        end
        end_test("range");

        start_test();
        setup_run(4'd3, 4'd6);
        wait_count(4'd6, 1'b1);
        wait_step();
        compare("led_count", 32'(led_count), 32'h5);
        wait_count(4'd3, 1'b0);
        wait_step();
        compare("led_count", 32'(led_count), 32'h4);
        end_test("turnaround");

        start_test();
        setup_run(4'd2, 4'd9);
        wait_count(4'd5, 1'b1);
        press_button(1'b0);
        wait_step();
        compare("led_count", 32'(led_count), 32'h4);
        compare("led_up", 32'(led_up), 32'h0);
        press_button(1'b1);
        wait_step();
        compare("led_count", 32'(led_count), 32'h2);
        compare("led_up", 32'(led_up), 32'h1);
        end_test("flip_restart");

        start_test();
        apb_write(pingpong_pkg::ADDR_CTRL, 32'h0, err);
        held = led_count;
        repeat (3 * pingpong_pkg::STEP_DIV) @(negedge clk);
        compare("led_count", 32'(led_count), 32'(held));
        apb_write(pingpong_pkg::ADDR_LIMITS, 32'h77, err);
        apb_write(pingpong_pkg::ADDR_CTRL, 32'h1, err);
        repeat (3 * pingpong_pkg::STEP_DIV) @(negedge clk);
        compare("led_count", 32'(led_count), 32'(held));
        apb_write(pingpong_pkg::ADDR_LIMITS, 32'hea, err);
        repeat (3 * pingpong_pkg::STEP_DIV) @(negedge clk);
        compare("led_count", 32'(led_count), 32'(held));
        end_test("holding");

        start_test();
        setup_run(4'd0, 4'd15);
        repeat (20) wait_step();
        end_test("display");

        $display("summary: %0d tests, %0d failed, %0d errors", tests, failed,
                 errors + i_pingpong_top.i_checker.fail_count);
        if (failed == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== pingpong.f ====
pingpong_pkg.sv
pingpong_regs.sv
button_conditioner.sv
tick_gen.sv
pingpong_counter.sv
display_driver.sv
pingpong_top.sv
pingpong_assertions.sv
tb_pingpong.sv

// ==== Makefile ====
TOP = tb_pingpong

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f pingpong.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f pingpong.f --top-module $(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee /dev/stderr | grep -q "all tests passed"

clean:
	rm -rf obj_dir
